// ==== include/ising_defs.svh ====
/* Sizing macros for the Ising coupling engine.
   Include wherever spin counts, weight widths or address widths are needed. */

`ifndef ISING_DEFS_SVH
`define ISING_DEFS_SVH

// ========================================
// Array sizing
// ========================================
`define N_SPINS   8   // Spins in the system.
`define WEIGHT_W  4   // Signed weight and bias width.
`define FIELD_W   8   // Signed local field, holds 7 weights plus a bias.

// ========================================
// Host address fields
// ========================================
`define COL_W     3   // Column index 0..N_SPINS-2.
`define ROW_W     3   // Row index 0..N_SPINS-1.

`endif

// ==== hdl/ising_pkg.sv ====
/* Shared types for the host command path and the local field vectors.
   Imported by every block that carries commands or fields. */

`default_nettype none

`include "ising_defs.svh"

package ising_pkg;

    // Register space selected by a host command.
    typedef enum logic [1:0] {
        TGT_WEIGHT = 2'd0,
        TGT_BIAS   = 2'd1,
        TGT_SPIN   = 2'd2
    } cfg_target_t;

    typedef struct packed {
        logic                 write;   // 1 = write, 0 = read.
        cfg_target_t          target;
        logic [`COL_W-1:0]    col;
        logic [`ROW_W-1:0]    row;
        logic [`WEIGHT_W-1:0] wdata;   // Spin writes use bit 0 only.
    } cfg_cmd_t;

    typedef struct packed {
        logic [`WEIGHT_W-1:0] rdata;
    } cfg_rsp_t;

    // Named signed element keeps each selected field signed.
    typedef logic signed [`FIELD_W-1:0] field_t;
    typedef field_t [`N_SPINS-1:0] field_vec_t;

endpackage

`default_nettype wire

// ==== hdl/cfg_port.sv ====
/* Host configuration slave on a four-phase req/ack handshake.
   Issues single-cycle write and read strobes and returns registered read data. */

`timescale 1ns/10ps
`default_nettype none

`include "ising_defs.svh"

module cfg_port import ising_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 cfg_req,
    input  wire cfg_cmd_t             cfg_cmd,
    output      logic                 cfg_ack,
    output      cfg_rsp_t             cfg_rsp,
    output      cfg_cmd_t             cmd,
    output      logic                 wr_stb,
    output      logic                 rd_stb,
    input  wire logic [`WEIGHT_W-1:0] weight_rdata,
    input  wire logic [`WEIGHT_W-1:0] bias_rdata,
    input  wire logic [`WEIGHT_W-1:0] spin_rdata
);

    logic                 start;
    logic [`WEIGHT_W-1:0] rd_sel;

    // A new request is only seen while ack is still low.
    assign start  = cfg_req & ~cfg_ack;
    assign wr_stb = start & cfg_cmd.write;
    assign rd_stb = start & ~cfg_cmd.write;
    assign cmd    = cfg_cmd;              // Host holds it stable under req.

    // ========================================
    // Readback select
    // ========================================
    always_comb begin
        case (cfg_cmd.target)
            TGT_WEIGHT: rd_sel = weight_rdata;
            TGT_BIAS:   rd_sel = bias_rdata;
            TGT_SPIN:   rd_sel = spin_rdata;
            default:    rd_sel = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_stb) begin
            cfg_rsp.rdata <= rd_sel;
        end
    end

    // ========================================
    // Handshake
    // ========================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_ack <= 1'b0;
        end else if (start) begin
            cfg_ack <= 1'b1;              // Held while req stays high.
        end else if (!cfg_req) begin
            cfg_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/coupled_cell.sv ====
/* One coupling weight between a source spin and a destination spin.
   Drives the signed contribution of the source spin and the stored weight. */

`timescale 1ns/10ps
`default_nettype none

`include "ising_defs.svh"

module coupled_cell import ising_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 wr_en,
    input  wire logic [`WEIGHT_W-1:0] wdata,
    input  wire logic                 sin,
    output      field_t               contrib,
    output      logic [`WEIGHT_W-1:0] rdata
);

    logic signed [`WEIGHT_W-1:0] weight;
    field_t                      weight_ext;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            weight <= '0;
        end else if (wr_en) begin
            weight <= wdata;
        end
    end

    // Widen first so that negating -8 does not wrap.
    assign weight_ext = {{(`FIELD_W - `WEIGHT_W){weight[`WEIGHT_W-1]}}, weight};
    assign contrib    = sin ? weight_ext : -weight_ext;  // Source spin -1 flips the sign.
    assign rdata      = weight;

endmodule

`default_nettype wire

// ==== hdl/coupled_col.sv ====
/* Column K of the coupling matrix, coupling spin i to spin (i+K+1) mod N.
   Holds one cell per row and reads back through a priority chain. */

`timescale 1ns/10ps
`default_nettype none

`include "ising_defs.svh"

module coupled_col import ising_pkg::*; #(
    parameter int K = 0
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 col_match,
    input  wire cfg_cmd_t             cmd,
    input  wire logic                 wr_stb,
    input  wire logic [`N_SPINS-1:0]  spins,
    output      field_vec_t           contribs,
    output      logic [`WEIGHT_W-1:0] rdata
);

    // Entry 0 is the default at the far end of the chain.
    logic [`N_SPINS:0][`WEIGHT_W-1:0] rd_chain;

    assign rd_chain[0] = '0;

    for (genvar i = 0; i < `N_SPINS; i++) begin : g_cell
        localparam int SRC = (i + K + 1) % `N_SPINS;  // Rotated source spin.

        logic                 row_hit;
        logic [`WEIGHT_W-1:0] cell_rdata;

        assign row_hit = (cmd.row == `ROW_W'(i));

        coupled_cell coupled_cell_inst (
            .clk     (clk),
            .arst_n  (arst_n),
            .wr_en   (wr_stb & col_match & row_hit),
            .wdata   (cmd.wdata),
            .sin     (spins[SRC]),
            .contrib (contribs[i]),
            .rdata   (cell_rdata)
        );

        // Matching row takes over the chain, others pass it on.
        assign rd_chain[i+1] = row_hit ? cell_rdata : rd_chain[i];
    end

    assign rdata = rd_chain[`N_SPINS];

endmodule

`default_nettype wire

// ==== hdl/coupling_matrix.sv ====
/* Full coupling matrix built from N_SPINS-1 rotated columns.
   Sums the coupling contributions per destination spin and decodes weight accesses. */

`timescale 1ns/10ps
`default_nettype none

`include "ising_defs.svh"

module coupling_matrix import ising_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire cfg_cmd_t             cmd,
    input  wire logic                 wr_stb,
    input  wire logic [`N_SPINS-1:0]  spins,
    output      field_vec_t           coupling_field,
    output      logic [`WEIGHT_W-1:0] rdata
);

    localparam int N_COLS = `N_SPINS - 1;

    field_vec_t           col_contribs [N_COLS];
    logic [`WEIGHT_W-1:0] col_rdata    [N_COLS];

    for (genvar k = 0; k < N_COLS; k++) begin : g_col
        coupled_col #(
            .K (k)
        ) coupled_col_inst (
            .clk       (clk),
            .arst_n    (arst_n),
            .col_match ((cmd.target == TGT_WEIGHT) && (cmd.col == `COL_W'(k))),
            .cmd       (cmd),
            .wr_stb    (wr_stb),
            .spins     (spins),
            .contribs  (col_contribs[k]),
            .rdata     (col_rdata[k])
        );
    end

    // ========================================
    // Field sum per destination row
    // ========================================
    always_comb begin
        for (int r = 0; r < `N_SPINS; r++) begin
            coupling_field[r] = '0;
            for (int k = 0; k < N_COLS; k++) begin
                coupling_field[r] = coupling_field[r] + col_contribs[k][r];
            end
        end
    end

    // Column index past the last column reads as zero.
    assign rdata = (cmd.col < `COL_W'(N_COLS)) ? col_rdata[cmd.col] : '0;

endmodule

`default_nettype wire

// ==== hdl/bias_bank.sv ====
/* Per-spin bias registers written and read by the host.
   Provides the biases sign-extended to field width. */

`timescale 1ns/10ps
`default_nettype none

`include "ising_defs.svh"

module bias_bank import ising_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire cfg_cmd_t             cmd,
    input  wire logic                 wr_stb,
    output      field_vec_t           bias_field,
    output      logic [`WEIGHT_W-1:0] rdata
);

    logic [`WEIGHT_W-1:0] bias [`N_SPINS];
    logic                 bias_wr;

    assign bias_wr = wr_stb & (cmd.target == TGT_BIAS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `N_SPINS; i++) begin
                bias[i] <= '0;
            end
        end else if (bias_wr) begin
            bias[cmd.row] <= cmd.wdata;
        end
    end

    for (genvar i = 0; i < `N_SPINS; i++) begin : g_ext
        assign bias_field[i] = {{(`FIELD_W - `WEIGHT_W){bias[i][`WEIGHT_W-1]}}, bias[i]};
    end

    assign rdata = bias[cmd.row];

endmodule

`default_nettype wire

// ==== hdl/spin_update.sv ====
/* Spin state with the synchronous sign update on each step request.
   Also loads and reads back single spins for the host. */

`timescale 1ns/10ps
`default_nettype none

`include "ising_defs.svh"

module spin_update import ising_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 step_req,
    output      logic                 step_ack,
    input  wire cfg_cmd_t             cmd,
    input  wire logic                 wr_stb,
    input  wire field_vec_t           coupling_field,
    input  wire field_vec_t           bias_field,
    output      logic [`N_SPINS-1:0]  spins,
    output      logic [`WEIGHT_W-1:0] rdata
);

    field_vec_t          total_field;
    logic [`N_SPINS-1:0] next_spins;
    logic                step_go;

    // ========================================
    // Sign rule
    // ========================================
    always_comb begin
        for (int i = 0; i < `N_SPINS; i++) begin
            total_field[i] = coupling_field[i] + bias_field[i];
            if (total_field[i] > 0) begin
                next_spins[i] = 1'b1;
            end else if (total_field[i] < 0) begin
                next_spins[i] = 1'b0;
            end else begin
                next_spins[i] = spins[i];  // Zero field keeps the spin.
            end
        end
    end

    assign step_go = step_req & ~step_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step_ack <= 1'b0;
        end else if (step_go) begin
            step_ack <= 1'b1;
        end else if (!step_req) begin
            step_ack <= 1'b0;
        end
    end

    // Step has priority over a host spin write.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            spins <= '0;                   // All spins -1.
        end else if (step_go) begin
            spins <= next_spins;
        end else if (wr_stb && cmd.target == TGT_SPIN) begin
            spins[cmd.row] <= cmd.wdata[0];
        end
    end

    assign rdata = {{(`WEIGHT_W - 1){1'b0}}, spins[cmd.row]};

endmodule

`default_nettype wire

// ==== hdl/ising_core.sv ====
/* Top level of the Ising coupling engine.
   Host configures weights, biases and spins, then requests update steps. */

`timescale 1ns/10ps
`default_nettype none

`include "ising_defs.svh"

module ising_core import ising_pkg::*; (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                cfg_req,
    input  wire cfg_cmd_t            cfg_cmd,
    output      logic                cfg_ack,
    output      cfg_rsp_t            cfg_rsp,
    input  wire logic                step_req,
    output      logic                step_ack,
    output      logic [`N_SPINS-1:0] spins
);

    cfg_cmd_t             cmd;
    logic                 wr_stb;
    logic [`WEIGHT_W-1:0] weight_rdata;
    logic [`WEIGHT_W-1:0] bias_rdata;
    logic [`WEIGHT_W-1:0] spin_rdata;
    field_vec_t           coupling_field;
    field_vec_t           bias_field;

    cfg_port cfg_port_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg_req      (cfg_req),
        .cfg_cmd      (cfg_cmd),
        .cfg_ack      (cfg_ack),
        .cfg_rsp      (cfg_rsp),
        .cmd          (cmd),
        .wr_stb       (wr_stb),
        .rd_stb       (),
        .weight_rdata (weight_rdata),
        .bias_rdata   (bias_rdata),
        .spin_rdata   (spin_rdata)
    );

    // ========================================
    // Field sources, side by side
    // ========================================
    coupling_matrix coupling_matrix_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .cmd            (cmd),
        .wr_stb         (wr_stb),
        .spins          (spins),
        .coupling_field (coupling_field),
        .rdata          (weight_rdata)
    );

    bias_bank bias_bank_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .wr_stb     (wr_stb),
        .bias_field (bias_field),
        .rdata      (bias_rdata)
    );

    spin_update spin_update_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .step_req       (step_req),
        .step_ack       (step_ack),
        .cmd            (cmd),
        .wr_stb         (wr_stb),
        .coupling_field (coupling_field),
        .bias_field     (bias_field),
        .spins          (spins),
        .rdata          (spin_rdata)
    );

endmodule

`default_nettype wire

// ==== test/tb_ising_core.sv ====
/* Testbench for the Ising coupling engine, driven by test/ising_tests.txt.
   Keeps its own model of weights, biases and spins to check reads and steps. */

`timescale 1ns/10ps
`default_nettype none

`include "ising_defs.svh"

module tb_ising_core import ising_pkg::*; ();

    logic                clk;
    logic                arst_n;
    logic                cfg_req;
    cfg_cmd_t            cfg_cmd;
    logic                cfg_ack;
    cfg_rsp_t            cfg_rsp;
    logic                step_req;
    logic                step_ack;
    logic [`N_SPINS-1:0] spins;

    // Reference model, indexed as [col][row] for weights.
    logic signed [`WEIGHT_W-1:0] w_model [`N_SPINS-1][`N_SPINS];
    logic signed [`WEIGHT_W-1:0] b_model [`N_SPINS];
    logic [`N_SPINS-1:0]         s_model;

    integer seed    = 32'h43f003ca;
    int     n_lines = 0;

    ising_core ising_core_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .cfg_req  (cfg_req),
        .cfg_cmd  (cfg_cmd),
        .cfg_ack  (cfg_ack),
        .cfg_rsp  (cfg_rsp),
        .step_req (step_req),
        .step_ack (step_ack),
        .spins    (spins)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic require_fields(input int got, input int want, input string what);
        if (got != want) begin
            $display("Could not parse a %s line in the tests file", what);
            $display("*** TEST FAILED ***");
            $fatal(1, "Bad tests file");
        end
    endtask

    function automatic logic [`WEIGHT_W-1:0] hex_value(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            hex_value = 4'(c - "0");
        end else if (c >= "a" && c <= "f") begin
            hex_value = 4'(c - "a" + 8'd10);
        end else begin
            $display("Bad hex digit in the tests file");
            $display("*** TEST FAILED ***");
            $fatal(1, "Bad tests file");
        end
    endfunction

    // ========================================
    // Reference model
    // ========================================
    function automatic logic [`N_SPINS-1:0] model_step();
        int                  f;
        int                  src;
        logic [`N_SPINS-1:0] nxt;
        for (int i = 0; i < `N_SPINS; i++) begin
            f = int'(b_model[`ROW_W'(i)]);
            for (int k = 0; k < `N_SPINS - 1; k++) begin
                src = (i + k + 1) % `N_SPINS;            // Column k row i is J(i, src).
                if (s_model[`ROW_W'(src)]) begin
                    f = f + int'(w_model[`COL_W'(k)][`ROW_W'(i)]);
                end else begin
                    f = f - int'(w_model[`COL_W'(k)][`ROW_W'(i)]);
                end
            end
            nxt[`ROW_W'(i)] = (f > 0) ? 1'b1 : (f < 0) ? 1'b0 : s_model[`ROW_W'(i)];
        end
        return nxt;
    endfunction

    function automatic logic [`WEIGHT_W-1:0] model_read(input int tgt, input int col,
                                                        input int row);
        case (tgt)
            0:       return w_model[`COL_W'(col)][`ROW_W'(row)];
            1:       return b_model[`ROW_W'(row)];
            default: return {{(`WEIGHT_W - 1){1'b0}}, s_model[`ROW_W'(row)]};
        endcase
    endfunction

    function automatic void model_write(input int tgt, input int col, input int row,
                                        input logic [`WEIGHT_W-1:0] data);
        case (tgt)
            0:       w_model[`COL_W'(col)][`ROW_W'(row)] = data;
            1:       b_model[`ROW_W'(row)] = data;
            default: s_model[`ROW_W'(row)] = data[0];
        endcase
    endfunction

    // ========================================
    // Handshake drivers
    // ========================================
    task automatic cfg_access(input logic wr, input int tgt, input int col, input int row,
                              input logic [`WEIGHT_W-1:0] data, input int hold,
                              output logic [`WEIGHT_W-1:0] rdata);
        @(negedge clk);
        check_value("cfg_ack before cfg_req", 32'(cfg_ack), 32'd0);
        @(posedge clk);
        cfg_cmd <= '{write: wr, target: cfg_target_t'(tgt[1:0]), col: col[`COL_W-1:0],
                     row: row[`ROW_W-1:0], wdata: data};
        cfg_req <= 1'b1;
        do @(negedge clk); while (!cfg_ack);
        rdata = cfg_rsp.rdata;
        repeat (hold) begin
            @(negedge clk);
            check_value("cfg_ack with cfg_req held", 32'(cfg_ack), 32'd1);
        end
        @(posedge clk);
        cfg_req <= 1'b0;
        do @(negedge clk); while (cfg_ack);
    endtask

    task automatic step_once(input int hold, input logic [`N_SPINS-1:0] expected);
        @(negedge clk);
        check_value("step_ack before step_req", 32'(step_ack), 32'd0);
        @(posedge clk);
        step_req <= 1'b1;
        do @(negedge clk); while (!step_ack);
        check_value("spins", 32'(spins), 32'(expected));
        repeat (hold) begin
            @(negedge clk);
            check_value("step_ack with step_req held", 32'(step_ack), 32'd1);
        end
        @(posedge clk);
        step_req <= 1'b0;
        do @(negedge clk); while (step_ack);
        check_value("spins after held step_req", 32'(spins), 32'(expected));  // One step only.
    endtask

    initial begin : watchdog
        wait (n_lines > 0);
        repeat (n_lines * 200) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", n_lines * 200);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog timeout");
    end

    initial begin : main
        int                   fd;
        int                   code;
        int                   tgt;
        int                   col;
        int                   row;
        int                   hold;
        logic [7:0]           op;
        logic [7:0]           c0;
        logic [7:0]           c1;
        logic [`WEIGHT_W-1:0] data;
        logic [`WEIGHT_W-1:0] rdata;
        logic [`WEIGHT_W-1:0] exp_rd;
        logic [`N_SPINS-1:0]  exp_spins;
        logic [`N_SPINS-1:0]  next_spins;
        logic [31:0]          rnd;
        logic [8*128-1:0]     line_buf;

        clk      = 1'b0;
        arst_n   = 1'b0;
        cfg_req  = 1'b0;
        cfg_cmd  = '0;
        step_req = 1'b0;
        s_model  = '0;
        for (int r = 0; r < `N_SPINS; r++) begin
            b_model[r] = '0;
            for (int k = 0; k < `N_SPINS - 1; k++) begin
                w_model[k][r] = '0;
            end
        end

        fd = $fopen("test/ising_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file test/ising_tests.txt");
            $display("*** TEST FAILED ***");
            $fatal(1, "No tests file");
        end
        while ($fgets(line_buf, fd) != 0) begin
            n_lines++;                                   // Sizes the watchdog.
        end
        $fclose(fd);
        fd = $fopen("test/ising_tests.txt", "r");

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // ========================================
        // One operation per line
        // ========================================
        while ($fscanf(fd, " %c", op) == 1) begin
            rnd  = $random(seed);
            hold = 1 + int'(rnd[1:0]);                   // Cycles with req held after ack.
            case (op)
                "W": begin
                    code = $fscanf(fd, " %d %d %d %c", tgt, col, row, c0);
                    require_fields(code, 4, "W");
                    if (c0 == "?") begin
                        rnd  = $random(seed);
                        data = rnd[`WEIGHT_W-1:0];
                    end else begin
                        data = hex_value(c0);
                    end
                    cfg_access(1'b1, tgt, col, row, data, hold, rdata);
                    model_write(tgt, col, row, data);
                end
                "R": begin
                    code   = $fscanf(fd, " %d %d %d %c", tgt, col, row, c0);
                    require_fields(code, 4, "R");
                    exp_rd = model_read(tgt, col, row);
                    if (c0 != "?") begin
                        check_value("tests file read value", 32'(hex_value(c0)), 32'(exp_rd));
                    end
                    cfg_access(1'b0, tgt, col, row, '0, hold, rdata);
                    check_value("cfg_rsp.rdata", 32'(rdata), 32'(exp_rd));
                end
                "S": begin
                    code       = $fscanf(fd, " %c", c0);
                    require_fields(code, 1, "S");
                    next_spins = model_step();
                    if (c0 != "?") begin
                        code      = $fscanf(fd, "%c", c1);
                        require_fields(code, 1, "S");
                        exp_spins = {hex_value(c0), hex_value(c1)};
                        check_value("tests file spins", 32'(exp_spins), 32'(next_spins));
                    end
                    step_once(hold, next_spins);
                    s_model = next_spins;
                end
                "#": begin
                    code = $fgets(line_buf, fd);
                end
                default: begin
                    $display("Unknown operation in the tests file");
                    $display("*** TEST FAILED ***");
                    $fatal(1, "Bad tests file");
                end
            endcase
        end
        $fclose(fd);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/ising_tests.txt ====
# W tgt col row data | R tgt col row expected | S spins (hex, bit i = spin i)
# tgt 0 weight, 1 bias, 2 spin; data one hex digit; ? = random data or model value
R 2 0 0 0
R 2 0 7 0
R 0 0 0 0
R 0 6 7 0
R 1 0 5 0
W 1 0 0 3
W 1 0 1 e
W 1 0 3 1
R 1 0 1 e
S 09
W 2 0 2 1
R 2 0 2 1
S 0d
W 0 2 5 d
R 0 2 5 d
R 0 2 4 0
R 0 1 5 0
R 0 3 5 0
W 0 6 4 5
W 0 0 2 a
S 19
W 2 0 3 0
S 0d
S 19
W 0 3 6 ?
W 0 4 1 ?
R 0 3 6 ?
S ?
S ?

// ==== compile.f ====
+incdir+include
hdl/ising_pkg.sv
hdl/cfg_port.sv
hdl/coupled_cell.sv
hdl/coupled_col.sv
hdl/coupling_matrix.sv
hdl/bias_bank.sv
hdl/spin_update.sv
hdl/ising_core.sv
test/tb_ising_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the Ising core testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_ising_core

./obj_dir/Vtb_ising_core > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
exit 0
